// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_flash_and_sd
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
src/flash_sd_pkg.sv
src/spi_select_regs.sv
src/spi_byte_engine.sv
src/flash_and_sd.sv
test/spi_device_model.sv
test/tb_flash_and_sd.sv

// ==== src/flash_and_sd.sv ====
`timescale 1ns/10ps
`default_nettype none

module flash_and_sd (
   input  logic                    clk,
   input  logic                    reset,
   // CPU bus
   input  logic [15:0]             a,
   input  logic                    iorq_n,
   input  logic                    rd_n,
   input  logic                    wr_n,
   input  flash_sd_pkg::zx_port_t  addr,      // Register number from the core
   input  logic                    ior,
   input  logic                    iow,
   input  flash_sd_pkg::spi_byte_t din,
   output flash_sd_pkg::spi_byte_t dout,
   output logic                    oe_n,
   // Configuration flash
   output logic                    flash_cs_n,
   output logic                    flash_clk,
   output logic                    flash_di,
   input  logic                    flash_do,
   // SD/MMC card
   output logic                    sd_cs_n,
   output logic                    sd_clk,
   output logic                    sd_mosi,
   input  logic                    sd_miso
);

   logic send_req;
   logic recv_req;
   logic card_selected;
   logic sclk;
   logic mosi;

   //////////////////////////////////////////////////
   // Decode and chip selects
   //////////////////////////////////////////////////

   spi_select_regs sel0 (
      .clk           (clk),
      .reset         (reset),
      .a             (a),
      .iorq_n        (iorq_n),
      .rd_n          (rd_n),
      .wr_n          (wr_n),
      .addr          (addr),
      .ior           (ior),
      .iow           (iow),
      .din           (din),
      .flash_cs_n    (flash_cs_n),
      .sd_cs_n       (sd_cs_n),
      .send_req      (send_req),
      .recv_req      (recv_req),
      .card_selected (card_selected)
   );

   // One shifter serves both devices
   spi_byte_engine eng0 (
      .clk           (clk),
      .reset         (reset),
      .send_req      (send_req),
      .recv_req      (recv_req),
      .din           (din),
      .card_selected (card_selected),
      .flash_miso    (flash_do),
      .sd_miso       (sd_miso),
      .dout          (dout),
      .oe_n          (oe_n),
      .sclk          (sclk),
      .mosi          (mosi)
   );

   // Shared clock and data out, CS picks the listener
   assign flash_clk = sclk;
   assign flash_di  = mosi;
   assign sd_clk    = sclk;
   assign sd_mosi   = mosi;

endmodule

`default_nettype wire

// ==== src/flash_sd_pkg.sv ====
`default_nettype none

package flash_sd_pkg;

   //////////////////////////////////////////////////
   // Bus and wire types
   //////////////////////////////////////////////////

   typedef logic [7:0] spi_byte_t;      // Byte on CPU data bus or SPI wire
   typedef logic [7:0] zx_port_t;       // Low I/O address or register number

   // Indirect register numbers
   localparam zx_port_t REG_SPI_DATA = 8'h02;   // SPI data, read and write
   localparam zx_port_t REG_FLASH_CS = 8'h03;   // Bit 0 drives flash CS

   // ZXMMC and DIVMMC card ports
   localparam zx_port_t PORT_ZXMMC_CS   = 8'h1F;
   localparam zx_port_t PORT_ZXMMC_SPI  = 8'h3F;
   localparam zx_port_t PORT_DIVMMC_CS  = 8'hE7;
   localparam zx_port_t PORT_DIVMMC_SPI = 8'hEB;

   //////////////////////////////////////////////////
   // SPI engine
   //////////////////////////////////////////////////

   localparam spi_byte_t   SPI_DUMMY_BYTE = 8'hFF;  // Sent on read-started transfers
   localparam int unsigned SPI_BITS       = 8;      // Bits per transfer

   typedef logic [$clog2(SPI_BITS)-1:0] spi_bit_cnt_t;
   localparam spi_bit_cnt_t SPI_LAST_BIT = spi_bit_cnt_t'(SPI_BITS - 1);

   typedef enum logic {
      SPI_IDLE,                         // Waiting for a request edge
      SPI_SHIFT                         // Clocking one byte out and in
   } spi_state_t;

endpackage

`default_nettype wire

// ==== src/spi_byte_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_byte_engine (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    send_req,      // High during data write
   input  logic                    recv_req,      // High during data read
   input  flash_sd_pkg::spi_byte_t din,
   input  logic                    card_selected, // SD is the MISO source
   input  logic                    flash_miso,
   input  logic                    sd_miso,
   output flash_sd_pkg::spi_byte_t dout,
   output logic                    oe_n,
   output logic                    sclk,
   output logic                    mosi
);

   flash_sd_pkg::spi_state_t   state;
   flash_sd_pkg::spi_bit_cnt_t bit_cnt;       // Bit in flight with MSB first
   flash_sd_pkg::spi_byte_t    tx_sr;         // Outgoing byte with top bit on wire
   flash_sd_pkg::spi_byte_t    rx_sr;         // Incoming bits
   flash_sd_pkg::spi_byte_t    rdata;         // Readback of last transfer
   flash_sd_pkg::spi_byte_t    load_byte;
   logic                       req;
   logic                       req_q;
   logic                       req_edge;
   logic                       miso;

   //////////////////////////////////////////////////
   // Request edge and CPU side
   //////////////////////////////////////////////////

   assign req      = send_req | recv_req;
   assign req_edge = req & ~req_q;            // One transfer per strobe

   always_ff @(posedge clk) begin
      if (reset)
         req_q <= 1'b0;
      else
         req_q <= req;                        // Tracked in SHIFT too so late edges drop
   end

   // Write sends CPU byte and read sends a dummy
   assign load_byte = send_req ? din : flash_sd_pkg::SPI_DUMMY_BYTE;

   assign miso = card_selected ? sd_miso : flash_miso;

   assign dout = rdata;                       // Always shows last received byte
   assign oe_n = ~recv_req;                   // Drive bus only during data read

   //////////////////////////////////////////////////
   // Transfer FSM
   //////////////////////////////////////////////////

   // 16 cycles in SHIFT with sclk toggling each clock
   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= flash_sd_pkg::SPI_IDLE;
         bit_cnt <= '0;
         sclk    <= 1'b0;
         mosi    <= 1'b1;                     // Idle line high
         rdata   <= flash_sd_pkg::SPI_DUMMY_BYTE;
      end else begin
         case (state)
            flash_sd_pkg::SPI_IDLE: begin
               if (req_edge) begin
                  state   <= flash_sd_pkg::SPI_SHIFT;
                  bit_cnt <= '0;
                  sclk    <= 1'b0;
                  mosi    <= load_byte[7];    // MSB ready before first rise
               end
            end
            flash_sd_pkg::SPI_SHIFT: begin
               if (!sclk) begin
                  sclk <= 1'b1;               // Rising edge samples MISO below
               end else begin
                  sclk <= 1'b0;               // Falling edge
                  if (bit_cnt == flash_sd_pkg::SPI_LAST_BIT) begin
                     state <= flash_sd_pkg::SPI_IDLE;
                     mosi  <= 1'b1;
                     rdata <= rx_sr;          // Readable from next cycle
                  end else begin
                     bit_cnt <= bit_cnt + flash_sd_pkg::spi_bit_cnt_t'(1);
                     mosi    <= tx_sr[6];     // Next bit on falling edge
                  end
               end
            end
            default: state <= flash_sd_pkg::SPI_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Shift registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (state == flash_sd_pkg::SPI_IDLE) begin
         if (req_edge)
            tx_sr <= load_byte;
      end else if (sclk) begin
         tx_sr <= {tx_sr[6:0], 1'b1};         // Advance with the falling edge
      end else begin
         rx_sr <= {rx_sr[6:0], miso};         // Sample as sclk rises
      end
   end

   // Select block must never decode a read and a write at once
   assert property (@(posedge clk) disable iff (reset) !(send_req && recv_req))
      else $error("spi_byte_engine: send and receive requested together");

   assert property (@(posedge clk) disable iff (reset)
                    (state == flash_sd_pkg::SPI_IDLE) |-> !sclk)
      else $error("spi_byte_engine: sclk high while idle");

endmodule

`default_nettype wire

// ==== src/spi_select_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_select_regs (
   input  logic                    clk,
   input  logic                    reset,
   // Direct Z80 I/O cycle
   input  logic [15:0]             a,           // Only low byte decoded
   input  logic                    iorq_n,
   input  logic                    rd_n,
   input  logic                    wr_n,
   // Indirect register access
   input  logic [7:0]              addr,        // Latched register number
   input  logic                    ior,
   input  logic                    iow,
   input  flash_sd_pkg::spi_byte_t din,
   // Chip selects and engine requests
   output logic                    flash_cs_n,
   output logic                    sd_cs_n,
   output logic                    send_req,    // Data port write
   output logic                    recv_req,    // Data port read
   output logic                    card_selected
);

   //////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////

   flash_sd_pkg::zx_port_t port_lo;
   flash_sd_pkg::zx_port_t reg_num;
   logic                   flash_cs_wr;     // Indirect CS register write
   logic                   card_cs_wr;      // ZXMMC or DIVMMC select write
   logic                   reg_data_hit;
   logic                   card_data_hit;

   assign port_lo = a[7:0];                 // Upper byte ignored like the real ports
   assign reg_num = addr;

   assign flash_cs_wr = iow && (reg_num == flash_sd_pkg::REG_FLASH_CS);

   assign card_cs_wr = !iorq_n && !wr_n &&
                       ((port_lo == flash_sd_pkg::PORT_ZXMMC_CS) ||
                        (port_lo == flash_sd_pkg::PORT_DIVMMC_CS));

   assign reg_data_hit  = (reg_num == flash_sd_pkg::REG_SPI_DATA);
   assign card_data_hit = !iorq_n &&
                          ((port_lo == flash_sd_pkg::PORT_ZXMMC_SPI) ||
                           (port_lo == flash_sd_pkg::PORT_DIVMMC_SPI));

   // Level requests, edge detect is in the engine
   assign send_req = (reg_data_hit && iow) || (card_data_hit && !wr_n);
   assign recv_req = (reg_data_hit && ior) || (card_data_hit && !rd_n);

   //////////////////////////////////////////////////
   // Chip-select registers
   //////////////////////////////////////////////////

   // Selecting one device always drops the other
   always_ff @(posedge clk) begin
      if (reset) begin
         flash_cs_n <= 1'b1;                // Both released
         sd_cs_n    <= 1'b1;
      end else if (flash_cs_wr) begin       // Indirect register has priority
         flash_cs_n <= din[0];
         sd_cs_n    <= 1'b1;
      end else if (card_cs_wr) begin
         sd_cs_n    <= din[0];
         flash_cs_n <= 1'b1;
      end
   end

   assign card_selected = !sd_cs_n;         // MISO source for the engine

   // Flash and card must never share the bus
   assert property (@(posedge clk) disable iff (reset) flash_cs_n || sd_cs_n)
      else $error("spi_select_regs: flash and SD selected together");

endmodule

`default_nettype wire

// ==== test/spi_device_model.sv ====
`timescale 1ns/10ps
`default_nettype none

// Mode-0 SPI slave for one device on the shared wires
module spi_device_model (
   input  logic                    cs_n,
   input  logic                    sclk,
   input  logic                    mosi,
   input  flash_sd_pkg::spi_byte_t reply,      // Byte shifted out on the next transfer
   output logic                    miso,
   output flash_sd_pkg::spi_byte_t last_byte,  // Last full byte seen on MOSI
   output logic [15:0]             byte_cnt
);

   flash_sd_pkg::spi_byte_t tx_sr;
   flash_sd_pkg::spi_byte_t rx_sr;
   logic [2:0]              bit_cnt;           // Bits received in current byte

   initial begin
      bit_cnt   = 3'd0;
      byte_cnt  = 16'd0;
      last_byte = 8'hFF;
      tx_sr     = 8'hFF;
      rx_sr     = 8'h00;
   end

   // First bit comes straight from reply before the first rise
   assign miso = cs_n ? 1'b1 : ((bit_cnt == 3'd0) ? reply[7] : tx_sr[7]);

   // Sample on the rise and shift out on the fall
   always @(posedge sclk or negedge sclk) begin
      if (!cs_n) begin
         if (sclk) begin
            rx_sr <= {rx_sr[6:0], mosi};       // Sample on rising edge
            if (bit_cnt == 3'd0)
               tx_sr <= reply;                 // Latch reply for the rest of the byte
            if (bit_cnt == 3'd7) begin
               last_byte <= {rx_sr[6:0], mosi};
               byte_cnt  <= byte_cnt + 16'd1;
            end
            bit_cnt <= bit_cnt + 3'd1;         // Wraps after 8 bits
         end else if (bit_cnt != 3'd0) begin
            tx_sr <= {tx_sr[6:0], 1'b1};       // No shift on the fall closing a byte
         end
      end
   end

endmodule

`default_nettype wire

// ==== test/tb_flash_and_sd.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_flash_and_sd;

   logic        clk;
   logic        reset;
   logic [15:0] a;
   logic        iorq_n, rd_n, wr_n;
   logic [7:0]  addr;
   logic        ior, iow;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        oe_n;
   logic        flash_cs_n, flash_clk, flash_di, flash_do;
   logic        sd_cs_n, sd_clk, sd_mosi, sd_miso;
   logic [7:0]  flash_reply, sd_reply;          // Model replies for next transfer
   logic [7:0]  flash_last, sd_last;
   logic [15:0] flash_cnt, sd_cnt;
   logic [9:0]  ref_state;                      // {flash_cs_n, sd_cs_n, readback}
   integer      seed;
   int          rises;
   int          errors;
   int          tests_run;
   int          tests_failed;

   flash_and_sd dut0 (
      .clk(clk), .reset(reset), .a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
      .addr(addr), .ior(ior), .iow(iow), .din(din), .dout(dout), .oe_n(oe_n),
      .flash_cs_n(flash_cs_n), .flash_clk(flash_clk), .flash_di(flash_di),
      .flash_do(flash_do), .sd_cs_n(sd_cs_n), .sd_clk(sd_clk), .sd_mosi(sd_mosi),
      .sd_miso(sd_miso)
   );

   spi_device_model flash_dev (
      .cs_n(flash_cs_n), .sclk(flash_clk), .mosi(flash_di), .reply(flash_reply),
      .miso(flash_do), .last_byte(flash_last), .byte_cnt(flash_cnt)
   );

   spi_device_model sd_dev (
      .cs_n(sd_cs_n), .sclk(sd_clk), .mosi(sd_mosi), .reply(sd_reply),
      .miso(sd_miso), .last_byte(sd_last), .byte_cnt(sd_cnt)
   );

   always #5 clk = ~clk;                        // 10 ns period

   always @(posedge flash_clk) rises <= rises + 1;   // Both devices share sclk

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   // Mode 0 indirect register, 1 Z80 port, 2 Z80 port with iorq_n high
   function automatic logic is_data(input int mode, input logic [7:0] port);
      if (mode == 0)
         return port == flash_sd_pkg::REG_SPI_DATA;
      if (mode == 1)
         return port == flash_sd_pkg::PORT_ZXMMC_SPI || port == flash_sd_pkg::PORT_DIVMMC_SPI;
      return 1'b0;
   endfunction

   function automatic logic [9:0] predict(input logic [9:0] st, input int mode,
                                          input logic [7:0] port, input logic wr,
                                          input logic [7:0] d, input logic [7:0] f_rep,
                                          input logic [7:0] s_rep);
      logic [9:0] nx;
      nx = st;
      if (mode == 0 && wr && port == flash_sd_pkg::REG_FLASH_CS) begin
         nx[9] = d[0];
         nx[8] = 1'b1;
      end else if (mode == 1 && wr && (port == flash_sd_pkg::PORT_ZXMMC_CS ||
                                       port == flash_sd_pkg::PORT_DIVMMC_CS)) begin
         nx[8] = d[0];
         nx[9] = 1'b1;
      end else if (is_data(mode, port)) begin
         if (!st[8])
            nx[7:0] = s_rep;                    // Card drives MISO
         else if (!st[9])
            nx[7:0] = f_rep;
         else
            nx[7:0] = 8'hFF;                    // Nobody selected so the line idles high
      end
      return nx;
   endfunction

   task automatic report_mismatch(input string what, input logic [15:0] got,
                                  input logic [15:0] exp);
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
   endtask

   // Idle is sclk low for 4 cycles in a row
   task automatic wait_idle();
      int quiet;
      int cycles;
      quiet  = 0;
      cycles = 0;
      while (quiet < 4 && cycles < 40) begin
         @(posedge clk);
         #1;
         cycles++;
         if (flash_clk == 1'b0)
            quiet++;
         else
            quiet = 0;
      end
      if (quiet < 4) begin
         $display("Timeout: the SPI engine did not go idle within 40 cycles");
         errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // Bus access with checks
   //////////////////////////////////////////////////

   task automatic do_access(input int mode, input logic [7:0] port, input logic wr,
                            input logic [7:0] d);
      logic [9:0]  exp;
      logic        xfer;
      logic [7:0]  got_rd;
      logic        got_oe;
      int          rises0;
      logic [15:0] fcnt0;
      logic [15:0] scnt0;
      logic [15:0] fcnt_exp;
      logic [15:0] scnt_exp;
      logic [31:0] rnd;
      logic [7:0]  sent;
      rnd         = $random(seed);
      flash_reply = rnd[7:0];
      sd_reply    = rnd[15:8];
      xfer        = is_data(mode, port);
      sent        = wr ? d : flash_sd_pkg::SPI_DUMMY_BYTE;
      exp         = predict(ref_state, mode, port, wr, d, flash_reply, sd_reply);
      rises0      = rises;
      fcnt0       = flash_cnt;
      scnt0       = sd_cnt;
      fcnt_exp    = fcnt0 + ((xfer && !ref_state[9]) ? 16'd1 : 16'd0);
      scnt_exp    = scnt0 + ((xfer && !ref_state[8]) ? 16'd1 : 16'd0);
      @(posedge clk);
      #1;
      din = d;
      if (mode == 0) begin
         addr = port;
         ior  = !wr;
         iow  = wr;
      end else begin
         a      = {rnd[23:16], port};           // Upper byte must not matter
         iorq_n = (mode == 2);
         rd_n   = wr;
         wr_n   = !wr;
      end
      repeat (3) @(posedge clk);
      #1;
      got_oe = oe_n;
      got_rd = dout;
      ior    = 1'b0;
      iow    = 1'b0;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
      addr   = 8'h00;
      a      = 16'h0000;
      wait_idle();
      if (got_oe !== !(xfer && !wr))
         report_mismatch("oe_n", {15'd0, got_oe}, {15'd0, !(xfer && !wr)});
      if (xfer && !wr && got_rd !== ref_state[7:0])
         report_mismatch("read data", {8'd0, got_rd}, {8'd0, ref_state[7:0]});
      if ({flash_cs_n, sd_cs_n} !== exp[9:8])
         report_mismatch("chip-selects", {14'd0, flash_cs_n, sd_cs_n}, {14'd0, exp[9:8]});
      if (dout !== exp[7:0])
         report_mismatch("readback", {8'd0, dout}, {8'd0, exp[7:0]});
      if (rises - rises0 != (xfer ? 8 : 0))
         report_mismatch("sclk rises", 16'(rises - rises0), xfer ? 16'd8 : 16'd0);
      if (flash_cnt !== fcnt_exp)
         report_mismatch("flash byte count", flash_cnt, fcnt_exp);
      if (sd_cnt !== scnt_exp)
         report_mismatch("sd byte count", sd_cnt, scnt_exp);
      if (xfer && !ref_state[9] && flash_last !== sent)
         report_mismatch("flash MOSI byte", {8'd0, flash_last}, {8'd0, sent});
      if (xfer && !ref_state[8] && sd_last !== sent)
         report_mismatch("sd MOSI byte", {8'd0, sd_last}, {8'd0, sent});
      ref_state = exp;
   endtask

   task automatic end_test(input string name, input int err_before);
      tests_run++;
      if (errors != err_before) begin
         tests_failed++;
         $display("test %s: failed", name);
      end else begin
         $display("test %s: ok", name);
      end
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   initial begin
      int          e0;
      int          i;
      int          idx;
      logic [31:0] rnd;
      logic [7:0]  ports [10];
      int          modes [10];
      logic        wrs   [10];
      seed         = 32'h2a99;
      clk          = 1'b0;
      reset        = 1'b1;
      a            = 16'h0000;
      iorq_n       = 1'b1;
      rd_n         = 1'b1;
      wr_n         = 1'b1;
      addr         = 8'h00;
      ior          = 1'b0;
      iow          = 1'b0;
      din          = 8'h00;
      flash_reply  = 8'hFF;
      sd_reply     = 8'hFF;
      rises        = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      ref_state    = {2'b11, 8'hFF};            // Both released and readback FF
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;

      e0 = errors;                              // Reset state
      if (flash_cs_n !== 1'b1 || sd_cs_n !== 1'b1 || oe_n !== 1'b1)
         report_mismatch("reset outputs", {13'd0, flash_cs_n, sd_cs_n, oe_n}, 16'h0007);
      if (flash_clk !== 1'b0 || sd_clk !== 1'b0 || flash_di !== 1'b1 || sd_mosi !== 1'b1)
         report_mismatch("reset serial lines",
                         {12'd0, flash_clk, sd_clk, flash_di, sd_mosi}, 16'h0003);
      do_access(0, flash_sd_pkg::REG_SPI_DATA, 1'b0, 8'h00);
      end_test("reset", e0);

      e0 = errors;
      do_access(0, flash_sd_pkg::REG_FLASH_CS, 1'b1, 8'h00);
      do_access(1, flash_sd_pkg::PORT_ZXMMC_CS, 1'b1, 8'h00);
      do_access(1, flash_sd_pkg::PORT_ZXMMC_CS, 1'b1, 8'h01);
      do_access(0, flash_sd_pkg::REG_FLASH_CS, 1'b1, 8'h00);
      do_access(1, flash_sd_pkg::PORT_DIVMMC_CS, 1'b1, 8'hFE);
      do_access(1, flash_sd_pkg::PORT_DIVMMC_CS, 1'b1, 8'h01);
      end_test("chip_selects", e0);

      e0 = errors;                              // Each device on each data port
      for (i = 0; i < 2; i++) begin
         if (i == 0)
            do_access(0, flash_sd_pkg::REG_FLASH_CS, 1'b1, 8'h00);
         else
            do_access(1, flash_sd_pkg::PORT_ZXMMC_CS, 1'b1, 8'h00);
         rnd = $random(seed);
         do_access(0, flash_sd_pkg::REG_SPI_DATA, 1'b1, rnd[7:0]);
         do_access(1, flash_sd_pkg::PORT_ZXMMC_SPI, 1'b1, rnd[15:8]);
         do_access(1, flash_sd_pkg::PORT_DIVMMC_SPI, 1'b1, rnd[23:16]);
      end
      end_test("send", e0);

      e0 = errors;                              // Reads return the previous reply
      do_access(1, flash_sd_pkg::PORT_DIVMMC_SPI, 1'b0, 8'h00);
      do_access(1, flash_sd_pkg::PORT_ZXMMC_SPI, 1'b0, 8'h00);
      do_access(0, flash_sd_pkg::REG_FLASH_CS, 1'b1, 8'h00);
      do_access(0, flash_sd_pkg::REG_SPI_DATA, 1'b0, 8'h00);
      do_access(0, flash_sd_pkg::REG_SPI_DATA, 1'b0, 8'h00);
      do_access(0, flash_sd_pkg::REG_FLASH_CS, 1'b1, 8'h01);
      do_access(0, flash_sd_pkg::REG_SPI_DATA, 1'b0, 8'h00);
      end_test("receive", e0);

      e0 = errors;                              // Nothing here may decode
      do_access(1, 8'h20, 1'b1, 8'h00);
      do_access(1, 8'h20, 1'b0, 8'h00);
      do_access(0, 8'h05, 1'b1, 8'h00);
      do_access(0, flash_sd_pkg::REG_FLASH_CS, 1'b0, 8'h00);
      do_access(2, flash_sd_pkg::PORT_ZXMMC_CS, 1'b1, 8'h00);
      do_access(2, flash_sd_pkg::PORT_ZXMMC_SPI, 1'b0, 8'h00);
      do_access(2, flash_sd_pkg::PORT_DIVMMC_SPI, 1'b1, 8'h5A);
      end_test("decode", e0);

      modes = '{0, 0, 0, 1, 1, 1, 1, 1, 1, 2};
      ports = '{8'h02, 8'h02, 8'h03, 8'h1F, 8'hE7, 8'h3F, 8'h3F, 8'hEB, 8'hEB, 8'h3F};
      wrs   = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
      e0 = errors;
      for (i = 0; i < 40; i++) begin
         rnd = $random(seed);
         idx = int'(rnd[15:8]) % 10;
         do_access(modes[idx], ports[idx], wrs[idx], rnd[7:0]);
      end
      end_test("random_mix", e0);

      $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
